// ==== all.f ====
+incdir+hw
hw/cpu_isa_pkg.sv
hw/cpu_bus_pkg.sv
hw/mem_bus_if.sv
hw/instr_decoder.sv
hw/alu8.sv
hw/reg_file.sv
hw/cpu_sequencer.sv
hw/cpu_core_top.sv
bench/cpu_mem_model.sv
bench/cpu_tb.sv

// ==== bench/cpu_mem_model.sv ====
// Memory model for the core testbench
// Holds the test program and a reference model of the instruction subset
// that predicts every bus access of the core in order
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_mem_model #(
	parameter int unsigned RNG_SEED = 1
) (
	input  logic               k_clk,
	input  logic               k_reset,
	input  cpu_bus_pkg::addr_t mem_addr_i,
	input  cpu_bus_pkg::byte_t mem_data_i,	// write data from the core
	input  logic               mem_we_i,
	input  logic               mem_oe_i,
	output cpu_bus_pkg::byte_t mem_data_o,	// read data to the core
	output logic               exp_we_o,
	output cpu_bus_pkg::addr_t exp_addr_o,
	output cpu_bus_pkg::byte_t exp_data_o,
	output logic               done_o
);

	localparam cpu_bus_pkg::addr_t CODE_BASE = 16'h0400;
	localparam cpu_bus_pkg::addr_t IDLE_LOOP = 16'h0800;
	localparam cpu_bus_pkg::addr_t LOOP_JMP = CODE_BASE + 16'h0033;	// jmp closing each pass
	localparam int NUM_PASSES = 3;
	localparam int IDLE_STEPS = 6;

	cpu_bus_pkg::byte_t mem [0:65535];
	logic [24:0] pending [$];	// expected accesses as {write, addr, data}
	logic [24:0] head;
	cpu_bus_pkg::addr_t asm_addr;
	cpu_bus_pkg::addr_t pc_m;
	cpu_bus_pkg::byte_t a_m;
	cpu_bus_pkg::byte_t b_m;
	logic z_m;
	int passes;
	int idle_count;
	int unsigned rng_seed;
	logic seeded;

	function automatic cpu_bus_pkg::byte_t random_byte();
		logic [31:0] r;
		r = $urandom;
		return r[7:0];
	endfunction

	// one instruction at asm_addr with the operand high byte first
	task automatic assemble(input cpu_bus_pkg::byte_t op, input cpu_bus_pkg::addr_t len,
		input cpu_bus_pkg::addr_t arg);
		mem[asm_addr] = op;
		if (len == 2)
			mem[asm_addr + 16'd1] = arg[7:0];
		if (len == 3)
		begin
			mem[asm_addr + 16'd1] = arg[15:8];
			mem[asm_addr + 16'd2] = arg[7:0];
		end
		asm_addr = asm_addr + len;
	endtask

	// new immediates for the next pass
	task automatic refresh_operands();
		mem[CODE_BASE + 16'h0001] = random_byte();	// lda
		mem[CODE_BASE + 16'h0006] = random_byte();	// ldb
		mem[CODE_BASE + 16'h000B] = random_byte();	// adda
		mem[CODE_BASE + 16'h0010] = random_byte();	// suba
		mem[CODE_BASE + 16'h0015] = random_byte() & 8'h07;	// small mask so zero is common
		mem[CODE_BASE + 16'h002A] = random_byte() | 8'h01;	// never zero
	endtask

	task automatic load_program();
		logic [16:0] i;
		for (i = 0; i < 17'h10000; i = i + 1)
			mem[i[15:0]] = i[15:8] ^ i[7:0] ^ 8'hA5;
		mem[`CPU_RESET_VECTOR] = CODE_BASE[15:8];
		mem[`CPU_RESET_VECTOR + 16'd1] = CODE_BASE[7:0];
		asm_addr = CODE_BASE;
		assemble(cpu_isa_pkg::OP_LDA_IMM, 2, 0);
		assemble(cpu_isa_pkg::OP_STA_EXT, 3, 16'h2000);
		assemble(cpu_isa_pkg::OP_LDB_IMM, 2, 0);
		assemble(cpu_isa_pkg::OP_STB_EXT, 3, 16'h2001);
		assemble(cpu_isa_pkg::OP_ADDA_IMM, 2, 0);
		assemble(cpu_isa_pkg::OP_STA_EXT, 3, 16'h2002);
		assemble(cpu_isa_pkg::OP_SUBA_IMM, 2, 0);
		assemble(cpu_isa_pkg::OP_STA_EXT, 3, 16'h2003);
		assemble(cpu_isa_pkg::OP_ANDA_IMM, 2, 0);
		assemble(cpu_isa_pkg::OP_BEQ, 2, 16'h0003);	// over the next store when zero
		assemble(cpu_isa_pkg::OP_STA_EXT, 3, 16'h2004);
		assemble(cpu_isa_pkg::OP_BNE, 2, 16'h0003);
		assemble(cpu_isa_pkg::OP_STB_EXT, 3, 16'h2005);
		assemble(cpu_isa_pkg::OP_LDA_IMM, 2, 0);	// z set
		assemble(cpu_isa_pkg::OP_BEQ, 2, 16'h0003);
		assemble(cpu_isa_pkg::OP_STA_EXT, 3, 16'h2006);
		assemble(cpu_isa_pkg::OP_BNE, 2, 16'h00F9);	// backward and not taken
		assemble(cpu_isa_pkg::OP_ADDA_IMM, 2, 0);
		assemble(cpu_isa_pkg::OP_BNE, 2, 16'h0001);	// hops over one byte
		assemble(8'h00, 1, 0);
		assemble(8'h01, 1, 0);	// undefined opcode
		assemble(cpu_isa_pkg::OP_NOP, 1, 0);
		assemble(cpu_isa_pkg::OP_STA_EXT, 3, 16'h2007);
		assemble(cpu_isa_pkg::OP_JMP_EXT, 3, CODE_BASE);
		asm_addr = IDLE_LOOP;
		assemble(cpu_isa_pkg::OP_NOP, 1, 0);
		assemble(cpu_isa_pkg::OP_NOP, 1, 0);
		assemble(cpu_isa_pkg::OP_JMP_EXT, 3, IDLE_LOOP);
		refresh_operands();
	endtask

	task automatic expect_read(input cpu_bus_pkg::addr_t addr);
		pending.push_back({1'b0, addr, 8'h00});
	endtask

	task automatic store_expected(input cpu_bus_pkg::addr_t addr, input cpu_bus_pkg::byte_t data);
		pending.push_back({1'b1, addr, data});
	endtask

	// runs the instruction at pc_m and queues the accesses it makes
	task automatic step_model();
		cpu_bus_pkg::byte_t op;
		cpu_bus_pkg::byte_t imm;
		cpu_bus_pkg::addr_t ea;
		logic taken;
		if (pc_m == LOOP_JMP)
		begin
			passes = passes + 1;
			if (passes >= NUM_PASSES)
			begin
				mem[LOOP_JMP + 16'd1] = IDLE_LOOP[15:8];	// leave for the idle loop
				mem[LOOP_JMP + 16'd2] = IDLE_LOOP[7:0];
			end
			else
				refresh_operands();
		end
		if (pc_m >= IDLE_LOOP)
			idle_count = idle_count + 1;
		op = mem[pc_m];
		imm = mem[pc_m + 16'd1];
		ea = {mem[pc_m + 16'd1], mem[pc_m + 16'd2]};
		expect_read(pc_m);
		case (op)
			cpu_isa_pkg::OP_LDA_IMM, cpu_isa_pkg::OP_LDB_IMM, cpu_isa_pkg::OP_ADDA_IMM,
			cpu_isa_pkg::OP_SUBA_IMM, cpu_isa_pkg::OP_ANDA_IMM:
			begin
				expect_read(pc_m + 16'd1);
				pc_m = pc_m + 16'd2;
				case (op)
					cpu_isa_pkg::OP_LDA_IMM:  a_m = imm;
					cpu_isa_pkg::OP_ADDA_IMM: a_m = a_m + imm;
					cpu_isa_pkg::OP_SUBA_IMM: a_m = a_m - imm;
					cpu_isa_pkg::OP_ANDA_IMM: a_m = a_m & imm;
					default:                  b_m = imm;
				endcase
				z_m = (op == cpu_isa_pkg::OP_LDB_IMM) ? (b_m == 8'h00) : (a_m == 8'h00);
			end
			cpu_isa_pkg::OP_STA_EXT, cpu_isa_pkg::OP_STB_EXT, cpu_isa_pkg::OP_JMP_EXT:
			begin
				expect_read(pc_m + 16'd1);
				expect_read(pc_m + 16'd2);
				pc_m = pc_m + 16'd3;
				if (op == cpu_isa_pkg::OP_JMP_EXT)
					pc_m = ea;
				else
					store_expected(ea, (op == cpu_isa_pkg::OP_STA_EXT) ? a_m : b_m);
			end
			cpu_isa_pkg::OP_BEQ, cpu_isa_pkg::OP_BNE:
			begin
				expect_read(pc_m + 16'd1);
				taken = (op == cpu_isa_pkg::OP_BEQ) ? z_m : !z_m;
				pc_m = pc_m + 16'd2;
				if (taken)
					pc_m = pc_m + {{8{imm[7]}}, imm};	// offset from the next opcode
			end
			default:
				pc_m = pc_m + 16'd1;	// nop and undefined opcodes
		endcase
	endtask

	initial
	begin
		mem_data_o = 8'h00;
		done_o = 1'b0;
		seeded = 1'b0;
	end

	always @(posedge k_clk)
	begin
		if (k_reset)
		begin
			if (!seeded)
			begin
				rng_seed = RNG_SEED;
				void'($urandom(rng_seed));	// fixed seed for the operand draws
				seeded = 1'b1;
			end
			load_program();
			pending.delete();
			expect_read(`CPU_RESET_VECTOR);
			expect_read(`CPU_RESET_VECTOR + 16'd1);
			pc_m = {mem[`CPU_RESET_VECTOR], mem[`CPU_RESET_VECTOR + 16'd1]};
			a_m = 8'h00;
			b_m = 8'h00;
			z_m = 1'b0;
			passes = 0;
			idle_count = 0;
			mem_data_o <= 8'h00;
			done_o <= 1'b0;
		end
		else
		begin
			if (mem_oe_i)
				mem_data_o <= mem[mem_addr_i];	// valid in the capture clock
			if (mem_we_i)
				mem[mem_addr_i] = mem_data_i;
			if ((mem_oe_i || mem_we_i) && (pending.size() > 0))
				head = pending.pop_front();
			if (pending.size() == 0)
				step_model();
			done_o <= (idle_count >= IDLE_STEPS);
		end
		head = pending[0];
		exp_we_o <= head[24];
		exp_addr_o <= head[23:8];
		exp_data_o <= head[7:0];
	end

endmodule

// ==== bench/cpu_tb.sv ====
// Testbench for the 8-bit core
// Runs the program from the memory model and checks every bus access
`timescale 1ns/1ps

module cpu_tb;

	localparam int RNG_SEED = 26506;
	// three passes of about 200 clocks each plus vector load and idle loop
	localparam int TIMEOUT_CYCLES = 2000;

	logic k_clk;
	logic k_reset;
	cpu_bus_pkg::addr_t mem_addr;
	cpu_bus_pkg::byte_t mem_wdata;
	cpu_bus_pkg::byte_t mem_rdata;
	logic mem_we;
	logic mem_oe;
	logic exp_we;
	cpu_bus_pkg::addr_t exp_addr;
	cpu_bus_pkg::byte_t exp_data;
	logic done;
	logic oe_last;
	logic we_last;
	logic first_seen;
	int clocks_after_reset;
	int cycles;
	int strobes;
	int value_errors;
	int protocol_errors;

	always #2 k_clk = ~k_clk;

	cpu_core_top cpu_core_top_inst (
		.k_clk      (k_clk),
		.k_reset    (k_reset),
		.mem_addr_o (mem_addr),
		.mem_data_o (mem_wdata),
		.mem_data_i (mem_rdata),
		.mem_we_o   (mem_we),
		.mem_oe_o   (mem_oe)
	);

	cpu_mem_model #(
		.RNG_SEED (RNG_SEED)
	) mem_model_inst (
		.k_clk      (k_clk),
		.k_reset    (k_reset),
		.mem_addr_i (mem_addr),
		.mem_data_i (mem_wdata),
		.mem_we_i   (mem_we),
		.mem_oe_i   (mem_oe),
		.mem_data_o (mem_rdata),
		.exp_we_o   (exp_we),
		.exp_addr_o (exp_addr),
		.exp_data_o (exp_data),
		.done_o     (done)
	);

	always @(posedge k_clk)
	begin
		if (!k_reset)
		begin
			cycles <= cycles + 1;
			if (!first_seen)
			begin
				clocks_after_reset = clocks_after_reset + 1;
				if (mem_oe || mem_we || (clocks_after_reset >= 3))
				begin
					first_seen = 1'b1;
					assert (mem_oe) else
					begin
						protocol_errors = protocol_errors + 1;
						$display("no read of the reset vector within 3 clocks after reset");
					end
				end
			end
			assert (!(mem_oe && mem_we)) else
			begin
				protocol_errors = protocol_errors + 1;
				$display("oe and we both high at %0t", $time);
			end
			assert (!(mem_oe && oe_last) && !(mem_we && we_last)) else
			begin
				protocol_errors = protocol_errors + 1;
				$display("strobe held for more than one clock at %0t", $time);
			end
			if (mem_oe || mem_we)
			begin
				strobes = strobes + 1;
				assert (mem_we == exp_we) else
				begin
					value_errors = value_errors + 1;
					$display("FAILED at %0t: mem_we_o = %b, expected %b", $time, mem_we, exp_we);
				end
				assert (mem_addr == exp_addr) else
				begin
					value_errors = value_errors + 1;
					$display("FAILED at %0t: mem_addr_o = %h, expected %h",
						$time, mem_addr, exp_addr);
				end
				if (mem_we && exp_we)
					assert (mem_wdata == exp_data) else
					begin
						value_errors = value_errors + 1;
						$display("FAILED at %0t: mem_data_o = %h, expected %h",
							$time, mem_wdata, exp_data);
					end
			end
			oe_last = mem_oe;
			we_last = mem_we;
		end
	end

	initial
	begin
		k_clk = 1'b0;
		k_reset = 1'b1;
		oe_last = 1'b0;
		we_last = 1'b0;
		first_seen = 1'b0;
		clocks_after_reset = 0;
		cycles = 0;
		strobes = 0;
		value_errors = 0;
		protocol_errors = 0;
		repeat (4) @(posedge k_clk);
		k_reset <= 1'b0;
		while (!done && (cycles < TIMEOUT_CYCLES))
			@(posedge k_clk);
		@(negedge k_clk);
		if (!done)
		begin
			protocol_errors = protocol_errors + 1;
			$display("timeout: program did not reach the idle loop within %0d clocks",
				TIMEOUT_CYCLES);
		end
		$display("bus accesses checked %0d, value errors %0d, protocol errors %0d",
			strobes, value_errors, protocol_errors);
		if ((value_errors == 0) && (protocol_errors == 0))
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== hw/alu8.sv ====
// 8-bit ALU with condition code generation
// Add and subtract update all four flags, pass and and keep carry
`timescale 1ns/1ps

module alu8 (
	input  cpu_bus_pkg::byte_t   a_i,	// accumulator
	input  cpu_bus_pkg::byte_t   b_i,	// immediate operand
	input  cpu_isa_pkg::alu_op_e op_i,
	input  cpu_isa_pkg::flags_t  flags_i,
	output cpu_bus_pkg::byte_t   result_o,
	output cpu_isa_pkg::flags_t  flags_o
);

	localparam int MSB = $bits(cpu_bus_pkg::byte_t) - 1;

	cpu_bus_pkg::byte_t result;
	logic carry;

	always_comb
	begin
		carry = 1'b0;
		result = b_i;
		flags_o = flags_i;
		case (op_i)
			cpu_isa_pkg::ALU_ADD:
			begin
				{carry, result} = {1'b0, a_i} + {1'b0, b_i};
				flags_o[cpu_isa_pkg::FLAG_V] = (a_i[MSB] == b_i[MSB]) && (result[MSB] != a_i[MSB]);
				flags_o[cpu_isa_pkg::FLAG_C] = carry;
			end
			cpu_isa_pkg::ALU_SUB:
			begin
				{carry, result} = {1'b0, a_i} - {1'b0, b_i};	// carry is the borrow
				flags_o[cpu_isa_pkg::FLAG_V] = (a_i[MSB] != b_i[MSB]) && (result[MSB] != a_i[MSB]);
				flags_o[cpu_isa_pkg::FLAG_C] = carry;
			end
			cpu_isa_pkg::ALU_AND:
			begin
				result = a_i & b_i;
				flags_o[cpu_isa_pkg::FLAG_V] = 1'b0;
			end
			default:
			begin
				result = b_i;	// plain load
				flags_o[cpu_isa_pkg::FLAG_V] = 1'b0;
			end
		endcase
		flags_o[cpu_isa_pkg::FLAG_N] = result[MSB];
		flags_o[cpu_isa_pkg::FLAG_Z] = (result == '0);
	end

	assign result_o = result;

endmodule

// ==== hw/cpu_bus_pkg.sv ====
// Memory bus types and the sequencer state set
`include "cpu_config.svh"

package cpu_bus_pkg;

	typedef logic [`CPU_ADDR_W-1:0] addr_t;
	typedef logic [`CPU_DATA_W-1:0] byte_t;

	// bus phases use _A address, _S strobe, _C capture
	typedef enum logic [4:0] {
		SEQ_RESET,
		SEQ_VEC_HI_A, SEQ_VEC_HI_S, SEQ_VEC_HI_C,
		SEQ_VEC_LO_A, SEQ_VEC_LO_S, SEQ_VEC_LO_C,
		SEQ_FETCH_A, SEQ_FETCH_S, SEQ_FETCH_C,
		SEQ_DECODE,
		SEQ_OPH_A, SEQ_OPH_S, SEQ_OPH_C,
		SEQ_OPL_A, SEQ_OPL_S, SEQ_OPL_C,
		SEQ_EXECUTE,
		SEQ_STORE_A, SEQ_STORE_S, SEQ_STORE_C,
		SEQ_BRANCH
	} seq_state_e;

endpackage

// ==== hw/cpu_config.svh ====
// Core configuration for the 8-bit processor
// Bus widths and the reset vector location
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// address bus width in bits
`define CPU_ADDR_W 16

// data bus width in bits
`define CPU_DATA_W 8

// high byte of the reset vector, low byte follows
`define CPU_RESET_VECTOR 16'hFFFE

`endif

// ==== hw/cpu_core_top.sv ====
// Top level of the 8-bit core
// Joins sequencer, decoder, ALU and registers and brings the bus out on pins
`timescale 1ns/1ps

module cpu_core_top (
	input  logic               k_clk,
	input  logic               k_reset,
	output cpu_bus_pkg::addr_t mem_addr_o,
	output cpu_bus_pkg::byte_t mem_data_o,
	input  cpu_bus_pkg::byte_t mem_data_i,
	output logic               mem_we_o,
	output logic               mem_oe_o
);

	mem_bus_if bus ();

	cpu_bus_pkg::byte_t opcode;
	cpu_bus_pkg::byte_t operand;
	cpu_bus_pkg::byte_t acc;
	cpu_bus_pkg::byte_t alu_result;
	cpu_bus_pkg::addr_t pc;
	cpu_bus_pkg::addr_t pc_next;
	cpu_isa_pkg::addr_mode_e mode;
	cpu_isa_pkg::alu_op_e alu_op;
	cpu_isa_pkg::dest_e dest;
	cpu_isa_pkg::flags_t flags;
	cpu_isa_pkg::flags_t alu_flags;
	logic cond;
	logic branch_taken;
	logic pc_load;
	logic pc_inc;
	logic acc_write;
	logic flags_write;

	cpu_sequencer cpu_sequencer_inst (
		.k_clk          (k_clk),
		.k_reset        (k_reset),
		.bus            (bus.master),
		.opcode_o       (opcode),
		.mode_i         (mode),
		.dest_i         (dest),
		.operand_o      (operand),
		.pc_i           (pc),
		.acc_i          (acc),
		.pc_load_o      (pc_load),
		.pc_next_o      (pc_next),
		.pc_inc_o       (pc_inc),
		.acc_write_o    (acc_write),
		.flags_write_o  (flags_write),
		.branch_taken_i (branch_taken)
	);

	instr_decoder instr_decoder_inst (
		.opcode_i (opcode),
		.mode_o   (mode),
		.alu_op_o (alu_op),
		.dest_o   (dest),
		.cond_o   (cond)
	);

	alu8 alu8_inst (
		.a_i      (acc),
		.b_i      (operand),
		.op_i     (alu_op),
		.flags_i  (flags),
		.result_o (alu_result),
		.flags_o  (alu_flags)
	);

	reg_file reg_file_inst (
		.k_clk          (k_clk),
		.k_reset        (k_reset),
		.dest_i         (dest),
		.result_i       (alu_result),
		.flags_i        (alu_flags),
		.acc_write_i    (acc_write),
		.flags_write_i  (flags_write),
		.pc_load_i      (pc_load),
		.pc_next_i      (pc_next),
		.pc_inc_i       (pc_inc),
		.cond_i         (cond),
		.acc_o          (acc),
		.flags_o        (flags),
		.pc_o           (pc),
		.branch_taken_o (branch_taken)
	);

	// pin side of the bus
	assign mem_addr_o = bus.addr;
	assign mem_data_o = bus.wdata;
	assign mem_we_o = bus.we;
	assign mem_oe_o = bus.oe;
	assign bus.rdata = mem_data_i;

endmodule

// ==== hw/cpu_isa_pkg.sv ====
// Instruction set types for the 8-bit core
// Opcodes, addressing modes, ALU operations, destinations and flags
`include "cpu_config.svh"

package cpu_isa_pkg;

	typedef logic [`CPU_DATA_W-1:0] opcode_t;

	// supported opcodes
	localparam opcode_t OP_LDA_IMM  = 8'h86;
	localparam opcode_t OP_LDB_IMM  = 8'hC6;
	localparam opcode_t OP_ADDA_IMM = 8'h8B;
	localparam opcode_t OP_SUBA_IMM = 8'h80;
	localparam opcode_t OP_ANDA_IMM = 8'h84;
	localparam opcode_t OP_STA_EXT  = 8'hB7;
	localparam opcode_t OP_STB_EXT  = 8'hF7;
	localparam opcode_t OP_JMP_EXT  = 8'h7E;
	localparam opcode_t OP_BEQ      = 8'h27;
	localparam opcode_t OP_BNE      = 8'h26;
	localparam opcode_t OP_NOP      = 8'h12;

	typedef enum logic [2:0] {
		MODE_NONE,	// unknown opcode, skipped
		MODE_INHERENT,
		MODE_IMMEDIATE,
		MODE_EXTENDED,
		MODE_REL8
	} addr_mode_e;

	typedef enum logic [1:0] {
		ALU_PASS,
		ALU_ADD,
		ALU_SUB,
		ALU_AND
	} alu_op_e;

	typedef enum logic [2:0] {
		DEST_NONE,
		DEST_A,
		DEST_B,
		DEST_MEM_A,	// store accumulator a
		DEST_MEM_B,	// store accumulator b
		DEST_PC
	} dest_e;

	// condition code bits, ordered n z v c
	typedef logic [3:0] flags_t;
	localparam int FLAG_N = 3;
	localparam int FLAG_Z = 2;
	localparam int FLAG_V = 1;
	localparam int FLAG_C = 0;

endpackage

// ==== hw/cpu_sequencer.sv ====
// Main sequencer of the core
// Runs the vector load, opcode and operand fetches, stores and branches.
// Every bus access is address, strobe and capture on three clocks
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_sequencer (
	input  logic                    k_clk,
	input  logic                    k_reset,
	mem_bus_if.master               bus,
	output cpu_bus_pkg::byte_t      opcode_o,
	input  cpu_isa_pkg::addr_mode_e mode_i,
	input  cpu_isa_pkg::dest_e      dest_i,
	output cpu_bus_pkg::byte_t      operand_o,
	input  cpu_bus_pkg::addr_t      pc_i,
	input  cpu_bus_pkg::byte_t      acc_i,
	output logic                    pc_load_o,
	output cpu_bus_pkg::addr_t      pc_next_o,
	output logic                    pc_inc_o,
	output logic                    acc_write_o,
	output logic                    flags_write_o,
	input  logic                    branch_taken_i
);

	cpu_bus_pkg::seq_state_e state, state_d;
	cpu_bus_pkg::byte_t opcode_q;
	cpu_bus_pkg::byte_t operand_q;
	cpu_bus_pkg::addr_t ea_q;	// vector value or extended address
	logic is_store;

	assign is_store = (dest_i == cpu_isa_pkg::DEST_MEM_A) || (dest_i == cpu_isa_pkg::DEST_MEM_B);

	always_ff @(posedge k_clk or posedge k_reset)
	begin
		if (k_reset)
			state <= cpu_bus_pkg::SEQ_RESET;
		else
			state <= state_d;
	end

	always_ff @(posedge k_clk)
	begin
		case (state)
			cpu_bus_pkg::SEQ_VEC_HI_C, cpu_bus_pkg::SEQ_OPH_C:
				ea_q[`CPU_ADDR_W-1:`CPU_DATA_W] <= bus.rdata;
			cpu_bus_pkg::SEQ_FETCH_C:
				opcode_q <= bus.rdata;
			cpu_bus_pkg::SEQ_OPL_C:
			begin
				operand_q <= bus.rdata;	// immediate value or branch offset
				ea_q[`CPU_DATA_W-1:0] <= bus.rdata;
			end
			default:
				ea_q <= ea_q;
		endcase
	end

	always_comb
	begin
		state_d = state;
		pc_load_o = 1'b0;
		pc_inc_o = 1'b0;
		acc_write_o = 1'b0;
		flags_write_o = 1'b0;
		pc_next_o = ea_q;
		case (state)
			cpu_bus_pkg::SEQ_RESET:    state_d = cpu_bus_pkg::SEQ_VEC_HI_A;
			cpu_bus_pkg::SEQ_VEC_HI_A: state_d = cpu_bus_pkg::SEQ_VEC_HI_S;
			cpu_bus_pkg::SEQ_VEC_HI_S: state_d = cpu_bus_pkg::SEQ_VEC_HI_C;
			cpu_bus_pkg::SEQ_VEC_HI_C: state_d = cpu_bus_pkg::SEQ_VEC_LO_A;
			cpu_bus_pkg::SEQ_VEC_LO_A: state_d = cpu_bus_pkg::SEQ_VEC_LO_S;
			cpu_bus_pkg::SEQ_VEC_LO_S: state_d = cpu_bus_pkg::SEQ_VEC_LO_C;
			cpu_bus_pkg::SEQ_VEC_LO_C:
			begin
				pc_load_o = 1'b1;
				pc_next_o = {ea_q[`CPU_ADDR_W-1:`CPU_DATA_W], bus.rdata};
				state_d = cpu_bus_pkg::SEQ_FETCH_A;
			end
			cpu_bus_pkg::SEQ_FETCH_A:  state_d = cpu_bus_pkg::SEQ_FETCH_S;
			cpu_bus_pkg::SEQ_FETCH_S:  state_d = cpu_bus_pkg::SEQ_FETCH_C;
			cpu_bus_pkg::SEQ_FETCH_C:
			begin
				pc_inc_o = 1'b1;
				state_d = cpu_bus_pkg::SEQ_DECODE;
			end
			cpu_bus_pkg::SEQ_DECODE:
				case (mode_i)
					cpu_isa_pkg::MODE_IMMEDIATE, cpu_isa_pkg::MODE_REL8:
						state_d = cpu_bus_pkg::SEQ_OPL_A;
					cpu_isa_pkg::MODE_EXTENDED:
						state_d = cpu_bus_pkg::SEQ_OPH_A;
					default:
						state_d = cpu_bus_pkg::SEQ_FETCH_A;	// nop or unknown opcode
				endcase
			cpu_bus_pkg::SEQ_OPH_A:    state_d = cpu_bus_pkg::SEQ_OPH_S;
			cpu_bus_pkg::SEQ_OPH_S:    state_d = cpu_bus_pkg::SEQ_OPH_C;
			cpu_bus_pkg::SEQ_OPH_C:
			begin
				pc_inc_o = 1'b1;
				state_d = cpu_bus_pkg::SEQ_OPL_A;
			end
			cpu_bus_pkg::SEQ_OPL_A:    state_d = cpu_bus_pkg::SEQ_OPL_S;
			cpu_bus_pkg::SEQ_OPL_S:    state_d = cpu_bus_pkg::SEQ_OPL_C;
			cpu_bus_pkg::SEQ_OPL_C:
			begin
				pc_inc_o = 1'b1;
				if (mode_i == cpu_isa_pkg::MODE_REL8)
					state_d = cpu_bus_pkg::SEQ_BRANCH;
				else if ((mode_i == cpu_isa_pkg::MODE_EXTENDED) && is_store)
					state_d = cpu_bus_pkg::SEQ_STORE_A;
				else
					state_d = cpu_bus_pkg::SEQ_EXECUTE;
			end
			cpu_bus_pkg::SEQ_EXECUTE:
			begin
				if (dest_i == cpu_isa_pkg::DEST_PC)
					pc_load_o = 1'b1;	// jmp to ea_q
				else
				begin
					acc_write_o = 1'b1;
					flags_write_o = 1'b1;
				end
				state_d = cpu_bus_pkg::SEQ_FETCH_A;
			end
			cpu_bus_pkg::SEQ_STORE_A:  state_d = cpu_bus_pkg::SEQ_STORE_S;
			cpu_bus_pkg::SEQ_STORE_S:  state_d = cpu_bus_pkg::SEQ_STORE_C;
			cpu_bus_pkg::SEQ_STORE_C:  state_d = cpu_bus_pkg::SEQ_FETCH_A;	// flags untouched
			cpu_bus_pkg::SEQ_BRANCH:
			begin
				// pc already points past the offset byte
				pc_next_o = pc_i + {{`CPU_DATA_W{operand_q[`CPU_DATA_W-1]}}, operand_q};
				pc_load_o = branch_taken_i;
				state_d = cpu_bus_pkg::SEQ_FETCH_A;
			end
			default:                   state_d = cpu_bus_pkg::SEQ_RESET;
		endcase
	end

	always_comb
	begin
		case (state)
			cpu_bus_pkg::SEQ_VEC_HI_A, cpu_bus_pkg::SEQ_VEC_HI_S, cpu_bus_pkg::SEQ_VEC_HI_C:
				bus.addr = `CPU_RESET_VECTOR;
			cpu_bus_pkg::SEQ_VEC_LO_A, cpu_bus_pkg::SEQ_VEC_LO_S, cpu_bus_pkg::SEQ_VEC_LO_C:
				bus.addr = `CPU_RESET_VECTOR + 16'd1;
			cpu_bus_pkg::SEQ_STORE_A, cpu_bus_pkg::SEQ_STORE_S, cpu_bus_pkg::SEQ_STORE_C:
				bus.addr = ea_q;
			default:
				bus.addr = pc_i;	// fetches run from the pc
		endcase
	end

	assign bus.oe = (state == cpu_bus_pkg::SEQ_VEC_HI_S) || (state == cpu_bus_pkg::SEQ_VEC_LO_S) ||
		(state == cpu_bus_pkg::SEQ_FETCH_S) || (state == cpu_bus_pkg::SEQ_OPH_S) ||
		(state == cpu_bus_pkg::SEQ_OPL_S);
	assign bus.we = (state == cpu_bus_pkg::SEQ_STORE_S);
	assign bus.wdata = acc_i;
	assign opcode_o = opcode_q;
	assign operand_o = operand_q;

endmodule

// ==== hw/instr_decoder.sv ====
// Opcode decoder
// Maps the supported opcodes onto mode, ALU operation and destination
`timescale 1ns/1ps

module instr_decoder (
	input  cpu_bus_pkg::byte_t      opcode_i,
	output cpu_isa_pkg::addr_mode_e mode_o,
	output cpu_isa_pkg::alu_op_e    alu_op_o,
	output cpu_isa_pkg::dest_e      dest_o,
	output logic                    cond_o	// 1 for beq, 0 for bne
);

	always_comb
	begin
		mode_o = cpu_isa_pkg::MODE_NONE;	// anything unlisted is skipped
		alu_op_o = cpu_isa_pkg::ALU_PASS;
		dest_o = cpu_isa_pkg::DEST_NONE;
		cond_o = 1'b0;
		case (opcode_i)
			cpu_isa_pkg::OP_LDA_IMM:
			begin
				mode_o = cpu_isa_pkg::MODE_IMMEDIATE;
				dest_o = cpu_isa_pkg::DEST_A;
			end
			cpu_isa_pkg::OP_LDB_IMM:
			begin
				mode_o = cpu_isa_pkg::MODE_IMMEDIATE;
				dest_o = cpu_isa_pkg::DEST_B;
			end
			cpu_isa_pkg::OP_ADDA_IMM:
			begin
				mode_o = cpu_isa_pkg::MODE_IMMEDIATE;
				alu_op_o = cpu_isa_pkg::ALU_ADD;
				dest_o = cpu_isa_pkg::DEST_A;
			end
			cpu_isa_pkg::OP_SUBA_IMM:
			begin
				mode_o = cpu_isa_pkg::MODE_IMMEDIATE;
				alu_op_o = cpu_isa_pkg::ALU_SUB;
				dest_o = cpu_isa_pkg::DEST_A;
			end
			cpu_isa_pkg::OP_ANDA_IMM:
			begin
				mode_o = cpu_isa_pkg::MODE_IMMEDIATE;
				alu_op_o = cpu_isa_pkg::ALU_AND;
				dest_o = cpu_isa_pkg::DEST_A;
			end
			cpu_isa_pkg::OP_STA_EXT:
			begin
				mode_o = cpu_isa_pkg::MODE_EXTENDED;
				dest_o = cpu_isa_pkg::DEST_MEM_A;
			end
			cpu_isa_pkg::OP_STB_EXT:
			begin
				mode_o = cpu_isa_pkg::MODE_EXTENDED;
				dest_o = cpu_isa_pkg::DEST_MEM_B;
			end
			cpu_isa_pkg::OP_JMP_EXT:
			begin
				mode_o = cpu_isa_pkg::MODE_EXTENDED;
				dest_o = cpu_isa_pkg::DEST_PC;
			end
			cpu_isa_pkg::OP_BEQ, cpu_isa_pkg::OP_BNE:
			begin
				mode_o = cpu_isa_pkg::MODE_REL8;
				dest_o = cpu_isa_pkg::DEST_PC;
				cond_o = (opcode_i == cpu_isa_pkg::OP_BEQ);
			end
			cpu_isa_pkg::OP_NOP:
				mode_o = cpu_isa_pkg::MODE_INHERENT;
			default:
				mode_o = cpu_isa_pkg::MODE_NONE;
		endcase
	end

endmodule

// ==== hw/mem_bus_if.sv ====
// Memory bus between the sequencer and the core pins
// Fixed three-clock access, no back-pressure
`timescale 1ns/1ps

interface mem_bus_if;

	cpu_bus_pkg::addr_t addr;
	cpu_bus_pkg::byte_t wdata;
	cpu_bus_pkg::byte_t rdata;
	logic we;	// write strobe, one clock
	logic oe;	// read strobe, data valid next clock

	modport master (
		output addr,
		output wdata,
		output we,
		output oe,
		input  rdata
	);

	// pin side view, as the top level sees the bus
	modport pins (
		input  addr,
		input  wdata,
		input  we,
		input  oe,
		output rdata
	);

endinterface

// ==== hw/reg_file.sv ====
// Programmer visible state of the core
// Accumulators a and b, condition flags and the program counter
`timescale 1ns/1ps

module reg_file (
	input  logic                k_clk,
	input  logic                k_reset,
	input  cpu_isa_pkg::dest_e  dest_i,
	input  cpu_bus_pkg::byte_t  result_i,
	input  cpu_isa_pkg::flags_t flags_i,
	input  logic                acc_write_i,
	input  logic                flags_write_i,
	input  logic                pc_load_i,
	input  cpu_bus_pkg::addr_t  pc_next_i,
	input  logic                pc_inc_i,
	input  logic                cond_i,
	output cpu_bus_pkg::byte_t  acc_o,
	output cpu_isa_pkg::flags_t flags_o,
	output cpu_bus_pkg::addr_t  pc_o,
	output logic                branch_taken_o
);

	cpu_bus_pkg::byte_t acc_a;
	cpu_bus_pkg::byte_t acc_b;
	cpu_isa_pkg::flags_t flags;
	cpu_bus_pkg::addr_t pc;

	always_ff @(posedge k_clk or posedge k_reset)
	begin
		if (k_reset)
		begin
			acc_a <= '0;
			acc_b <= '0;
			flags <= '0;
		end
		else
		begin
			if (acc_write_i && (dest_i == cpu_isa_pkg::DEST_A))
				acc_a <= result_i;
			if (acc_write_i && (dest_i == cpu_isa_pkg::DEST_B))
				acc_b <= result_i;
			if (flags_write_i)
				flags <= flags_i;
		end
	end

	// first loaded from the reset vector
	always_ff @(posedge k_clk)
	begin
		if (pc_load_i)
			pc <= pc_next_i;
		else if (pc_inc_i)
			pc <= pc + 1'b1;
	end

	// stores read the same accumulator they name
	assign acc_o = ((dest_i == cpu_isa_pkg::DEST_B) || (dest_i == cpu_isa_pkg::DEST_MEM_B)) ?
		acc_b : acc_a;
	assign flags_o = flags;
	assign pc_o = pc;
	assign branch_taken_o = (flags[cpu_isa_pkg::FLAG_Z] == cond_i);	// beq on z set and bne on z clear

endmodule
